// File: Makefile
# Verilator build and run of the issue stage testbench

VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = tb_exec_cluster
FILELIST  = sim.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "TEST OK" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation did not pass, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: hdl/alu_unit.sv
/*
 * One-cycle integer ALU that drives the result bypass bus
 */

`timescale 1ns/1ps

module alu_unit (
	input  logic clk,
	input  logic rst,
	issue_if.fu iss,
	output logic res_v_o,
	output logic [rs_pkg::PREG_W-1:0] res_dst_o,
	output logic [rs_pkg::DATA_W-1:0] res_data_o
);
	import rs_pkg::*;

	logic [DATA_W-1:0] result;

	// NOP and any unused encoding give zero
	always_comb begin
		case (iss.op)
			OP_LI:   result = iss.imm;
			OP_ADD:  result = iss.a + iss.b;
			OP_SUB:  result = iss.a - iss.b;
			OP_AND:  result = iss.a & iss.b;
			OP_XOR:  result = iss.a ^ iss.b;
			default: result = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst)
			res_v_o <= 1'b0;
		else
			res_v_o <= iss.v;
	end

	// Destination and data sit on the bus for one cycle with res_v_o
	always_ff @(posedge clk) begin
		if (iss.v) begin
			res_dst_o <= iss.dst;
			res_data_o <= result;
		end
	end

endmodule

// File: hdl/exec_cluster_top.sv
/*
 * Issue stage top level with reservation station, register file
 * and ALU joined by the issue bundle and the bypass bus
 */

`timescale 1ns/1ps

module exec_cluster_top #(
	parameter int NRSE = 4
) (
	input  logic clk,
	input  logic rst,
	input  logic dispatch_i,
	input  rs_pkg::opcode_e op_i,
	input  logic [rs_pkg::DATA_W-1:0] imm_i,
	input  logic [rs_pkg::ROB_W-1:0] rob_i,
	input  logic [rs_pkg::PREG_W-1:0] dst_i,
	input  logic [rs_pkg::PREG_W-1:0] src_a_i,
	input  logic [rs_pkg::PREG_W-1:0] src_b_i,
	input  logic stall_i,
	input  logic [2**rs_pkg::ROB_W-1:0] stomp_i,
	output logic busy_o,
	output logic result_valid_o,
	output logic [rs_pkg::PREG_W-1:0] result_dst_o,
	output logic [rs_pkg::DATA_W-1:0] result_data_o
);
	import rs_pkg::*;

	issue_if iss_bus ();

	logic res_v;
	logic [PREG_W-1:0] res_dst;
	logic [DATA_W-1:0] res_data;
	logic [NRPORT-1:0] req_v;
	logic [NRPORT-1:0][PREG_W-1:0] req_rn;
	rf_port_t [NRPORT-1:0] rf_rsp;
	logic inv_v;

	// The destination goes pending on the same edge the station accepts it
	assign inv_v = dispatch_i && !busy_o;

	reservation_station #(.NRSE(NRSE)) u_rs (
		.clk(clk),
		.rst(rst),
		.dispatch_i(dispatch_i),
		.op_i(op_i),
		.imm_i(imm_i),
		.rob_i(rob_i),
		.dst_i(dst_i),
		.src_a_i(src_a_i),
		.src_b_i(src_b_i),
		.stall_i(stall_i),
		.stomp_i(stomp_i),
		.rf_i(rf_rsp),
		.res_v_i(res_v),
		.res_dst_i(res_dst),
		.res_data_i(res_data),
		.req_v_o(req_v),
		.req_rn_o(req_rn),
		.busy_o(busy_o),
		.iss(iss_bus.rs)
	);

	reg_file u_rf (
		.clk(clk),
		.rst(rst),
		.req_v_i(req_v),
		.req_rn_i(req_rn),
		.rf_o(rf_rsp),
		.inv_v_i(inv_v),
		.inv_rn_i(dst_i),
		.res_v_i(res_v),
		.res_dst_i(res_dst),
		.res_data_i(res_data)
	);

	alu_unit u_alu (
		.clk(clk),
		.rst(rst),
		.iss(iss_bus.fu),
		.res_v_o(res_v),
		.res_dst_o(res_dst),
		.res_data_o(res_data)
	);

	// The bypass bus doubles as the result port
	assign result_valid_o = res_v;
	assign result_dst_o = res_dst;
	assign result_data_o = res_data;

endmodule

// File: hdl/issue_if.sv
/*
 * Issue bundle from the reservation station to the ALU
 */

`timescale 1ns/1ps

interface issue_if;
	import rs_pkg::*;

	// A high v on an edge is exactly one operation, the ALU never pushes back
	logic v;
	opcode_e op;
	logic [DATA_W-1:0] a;
	logic [DATA_W-1:0] b;
	logic [DATA_W-1:0] imm;
	logic [PREG_W-1:0] dst;

	modport rs (output v, op, a, b, imm, dst);
	modport fu (input v, op, a, b, imm, dst);

endinterface

// File: hdl/operand_capture.sv
/*
 * Tag match of one operand slot of every station entry against
 * the register read ports and the result bypass bus
 */

`timescale 1ns/1ps

module operand_capture #(
	parameter int NRSE = 4
) (
	input  rs_pkg::operand_t [NRSE-1:0] oper_i,
	input  rs_pkg::rf_port_t [rs_pkg::NRPORT-1:0] rf_i,
	input  logic res_v_i,
	input  logic [rs_pkg::PREG_W-1:0] res_dst_i,
	input  logic [rs_pkg::DATA_W-1:0] res_data_i,
	output rs_pkg::operand_t [NRSE-1:0] oper_o
);
	import rs_pkg::*;

	always_comb begin
		oper_o = oper_i;
		for (int i = 0; i < NRSE; i++) begin
			// Operands that already hold a value are left alone
			if (!oper_i[i].v) begin
				// A read port answer only counts when the register was valid
				for (int p = 0; p < NRPORT; p++) begin
					if (rf_i[p].v && rf_i[p].rn == oper_i[i].rn) begin
						oper_o[i].v = 1'b1;
						oper_o[i].val = rf_i[p].val;
					end
				end
				// Bypass is checked last so it overrides a port hit
				if (res_v_i && res_dst_i == oper_i[i].rn) begin
					oper_o[i].v = 1'b1;
					oper_o[i].val = res_data_i;
				end
			end
		end
	end

endmodule

// File: hdl/reg_file.sv
/*
 * Physical register file with valid bits, read ports for the
 * station, invalidate on dispatch and write from the bypass bus
 */

`timescale 1ns/1ps

module reg_file (
	input  logic clk,
	input  logic rst,
	input  logic [rs_pkg::NRPORT-1:0] req_v_i,
	input  logic [rs_pkg::NRPORT-1:0][rs_pkg::PREG_W-1:0] req_rn_i,
	output rs_pkg::rf_port_t [rs_pkg::NRPORT-1:0] rf_o,
	input  logic inv_v_i,
	input  logic [rs_pkg::PREG_W-1:0] inv_rn_i,
	input  logic res_v_i,
	input  logic [rs_pkg::PREG_W-1:0] res_dst_i,
	input  logic [rs_pkg::DATA_W-1:0] res_data_i
);
	import rs_pkg::*;

	localparam int NPREG = 2**PREG_W;

	logic [DATA_W-1:0] regs_q [NPREG];
	logic [NPREG-1:0] vld_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			// Every register comes out of reset holding a valid zero
			for (int r = 0; r < NPREG; r++)
				regs_q[r] <= '0;
			vld_q <= '1;
		end else begin
			if (res_v_i) begin
				regs_q[res_dst_i] <= res_data_i;
				vld_q[res_dst_i] <= 1'b1;
			end
			// Last assignment wins, so a new producer keeps its register pending
			if (inv_v_i)
				vld_q[inv_rn_i] <= 1'b0;
		end
	end

	// Same-cycle answer, valid only for a requested register that is valid
	always_comb begin
		for (int p = 0; p < NRPORT; p++) begin
			rf_o[p].v = req_v_i[p] && vld_q[req_rn_i[p]];
			rf_o[p].rn = req_rn_i[p];
			rf_o[p].val = regs_q[req_rn_i[p]];
		end
	end

endmodule

// File: hdl/reservation_station.sv
/*
 * Reservation station with dispatch into the lowest free entry,
 * operand wakeup, registered ready, lowest-entry issue and stomp
 */

`timescale 1ns/1ps

module reservation_station #(
	parameter int NRSE = 4
) (
	input  logic clk,
	input  logic rst,
	input  logic dispatch_i,
	input  rs_pkg::opcode_e op_i,
	input  logic [rs_pkg::DATA_W-1:0] imm_i,
	input  logic [rs_pkg::ROB_W-1:0] rob_i,
	input  logic [rs_pkg::PREG_W-1:0] dst_i,
	input  logic [rs_pkg::PREG_W-1:0] src_a_i,
	input  logic [rs_pkg::PREG_W-1:0] src_b_i,
	input  logic stall_i,
	input  logic [2**rs_pkg::ROB_W-1:0] stomp_i,
	input  rs_pkg::rf_port_t [rs_pkg::NRPORT-1:0] rf_i,
	input  logic res_v_i,
	input  logic [rs_pkg::PREG_W-1:0] res_dst_i,
	input  logic [rs_pkg::DATA_W-1:0] res_data_i,
	output logic [rs_pkg::NRPORT-1:0] req_v_o,
	output logic [rs_pkg::NRPORT-1:0][rs_pkg::PREG_W-1:0] req_rn_o,
	output logic busy_o,
	issue_if.rs iss
);
	import rs_pkg::*;

	localparam int IDX_W = $clog2(NRSE);

	rs_entry_t ent_q [NRSE];
	rs_entry_t new_ent;
	operand_t [NRSE-1:0] opa;
	operand_t [NRSE-1:0] opb;
	operand_t [NRSE-1:0] cap_a;
	operand_t [NRSE-1:0] cap_b;
	logic [NRSE-1:0] busy_vec;
	// Marks the entry written on the last edge so ready waits one more cycle
	logic [NRSE-1:0] fresh_q;
	logic pstall_q;
	logic [IDX_W-1:0] free_idx;
	logic [IDX_W-1:0] sel_idx;
	logic sel_v;
	logic accept;
	logic issue_go;

	// ============================================================
	// Operand wakeup
	// ============================================================

	always_comb begin
		for (int i = 0; i < NRSE; i++) begin
			opa[i] = ent_q[i].a;
			opb[i] = ent_q[i].b;
			busy_vec[i] = ent_q[i].busy;
		end
	end

	operand_capture #(.NRSE(NRSE)) u_cap_a (
		.oper_i(opa),
		.rf_i(rf_i),
		.res_v_i(res_v_i),
		.res_dst_i(res_dst_i),
		.res_data_i(res_data_i),
		.oper_o(cap_a)
	);

	operand_capture #(.NRSE(NRSE)) u_cap_b (
		.oper_i(opb),
		.rf_i(rf_i),
		.res_v_i(res_v_i),
		.res_dst_i(res_dst_i),
		.res_data_i(res_data_i),
		.oper_o(cap_b)
	);

	// Missing operands ask for a register read, entry order first
	always_comb begin
		int k;
		req_v_o = '0;
		req_rn_o = '0;
		k = 0;
		for (int i = 0; i < NRSE; i++) begin
			if (ent_q[i].busy && !ent_q[i].a.v && k < NRPORT) begin
				req_v_o[k] = 1'b1;
				req_rn_o[k] = ent_q[i].a.rn;
				k = k + 1;
			end
			if (ent_q[i].busy && !ent_q[i].b.v && k < NRPORT) begin
				req_v_o[k] = 1'b1;
				req_rn_o[k] = ent_q[i].b.rn;
				k = k + 1;
			end
		end
	end

	// ============================================================
	// Dispatch and issue selection
	// ============================================================

	assign busy_o = &busy_vec;
	assign accept = dispatch_i && !busy_o;
	// Two quiet stall edges in a row are needed before anything leaves
	assign issue_go = sel_v && !stall_i && !pstall_q;

	// Walking down from the top leaves the lowest hit in the index
	always_comb begin
		free_idx = '0;
		sel_idx = '0;
		sel_v = 1'b0;
		for (int i = NRSE - 1; i >= 0; i--) begin
			if (!ent_q[i].busy)
				free_idx = IDX_W'(i);
			if (ent_q[i].ready) begin
				sel_idx = IDX_W'(i);
				sel_v = 1'b1;
			end
		end
	end

	// A load immediate needs no sources, so both slots start out valid
	always_comb begin
		new_ent = '0;
		new_ent.busy = 1'b1;
		new_ent.op = op_i;
		new_ent.imm = imm_i;
		new_ent.rob = rob_i;
		new_ent.dst = dst_i;
		new_ent.a.v = (op_i == OP_LI);
		new_ent.a.rn = src_a_i;
		new_ent.b.v = (op_i == OP_LI);
		new_ent.b.rn = src_b_i;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < NRSE; i++) begin
				ent_q[i].busy <= 1'b0;
				ent_q[i].ready <= 1'b0;
			end
			fresh_q <= '0;
			pstall_q <= 1'b0;
			iss.v <= 1'b0;
		end else begin
			pstall_q <= stall_i;
			fresh_q <= '0;
			iss.v <= 1'b0;
			for (int i = 0; i < NRSE; i++) begin
				if (ent_q[i].busy) begin
					ent_q[i].a <= cap_a[i];
					ent_q[i].b <= cap_b[i];
				end
				// Ready looks at the stored operands, one cycle behind capture
				ent_q[i].ready <= ent_q[i].busy && ent_q[i].a.v && ent_q[i].b.v &&
					!fresh_q[i];
			end
			if (accept) begin
				ent_q[free_idx] <= new_ent;
				fresh_q[free_idx] <= 1'b1;
			end
			if (issue_go) begin
				ent_q[sel_idx].busy <= 1'b0;
				ent_q[sel_idx].ready <= 1'b0;
				iss.v <= 1'b1;
			end
		end
	end

	// Issue payload, a stomped entry still goes out but as a NOP
	always_ff @(posedge clk) begin
		if (issue_go) begin
			iss.op <= stomp_i[ent_q[sel_idx].rob] ? OP_NOP : ent_q[sel_idx].op;
			iss.a <= ent_q[sel_idx].a.val;
			iss.b <= ent_q[sel_idx].b.val;
			iss.imm <= ent_q[sel_idx].imm;
			iss.dst <= ent_q[sel_idx].dst;
		end
	end

endmodule

// File: hdl/rs_pkg.sv
/*
 * Shared widths, opcode enum and the operand, read-port and
 * station entry structs of the issue stage
 */

package rs_pkg;

	// Datapath and register numbering
	localparam int DATA_W = 16;
	localparam int PREG_W = 4;
	localparam int ROB_W = 2;

	// Register file read ports that serve the station
	localparam int NRPORT = 2;

	typedef enum logic [2:0] {
		OP_NOP = 3'd0,
		OP_LI  = 3'd1,
		OP_ADD = 3'd2,
		OP_SUB = 3'd3,
		OP_AND = 3'd4,
		OP_XOR = 3'd5
	} opcode_e;

	// One source operand as held in a station entry
	typedef struct packed {
		logic v;
		logic [PREG_W-1:0] rn;
		logic [DATA_W-1:0] val;
	} operand_t;

	// Answer of one register file read port
	typedef struct packed {
		logic v;
		logic [PREG_W-1:0] rn;
		logic [DATA_W-1:0] val;
	} rf_port_t;

	typedef struct packed {
		logic busy;
		logic ready;
		opcode_e op;
		logic [DATA_W-1:0] imm;
		logic [ROB_W-1:0] rob;
		logic [PREG_W-1:0] dst;
		operand_t a;
		operand_t b;
	} rs_entry_t;

endpackage

// File: sim.f
hdl/rs_pkg.sv
hdl/issue_if.sv
hdl/operand_capture.sv
hdl/reservation_station.sv
hdl/reg_file.sv
hdl/alu_unit.sv
hdl/exec_cluster_top.sv
test/tb_exec_cluster.sv

// File: test/rs_stimulus.txt
# T name | D op imm rob dst src_a src_b expected latency | S stall | K stomp_mask | B busy
# I cycles | W waits for all results. Fields are hex, the latency is decimal and 0 skips it
T li_write
D LI 1234 0 1 0 0 1234 4
W
T dep_chain
D LI 00f0 0 2 0 0 00f0 0
D LI 003c 1 3 0 0 003c 0
D ADD 0000 2 4 2 3 012c 0
D SUB 0000 3 5 4 3 00f0 0
D AND 0000 0 6 5 4 0020 0
W
D XOR 0000 1 7 6 2 00d0 0
W
T in_order
S 1
D LI 0011 0 8 0 0 0011 10
D LI 0022 1 9 0 0 0022 10
D LI 0033 2 a 0 0 0033 10
D LI 0044 3 b 0 0 0044 10
I 4
S 0
W
T busy_fill
S 1
D LI 0707 0 1 0 0 0707 0
D ADD 0000 1 2 1 1 0e0e 0
D SUB 0000 2 3 1 0 0707 0
D XOR 0000 3 4 1 7 07d7 0
B 1
S 0
W
T stall_hold
D LI 0100 0 c 0 0 0100 4
D LI 0200 1 d 0 0 0200 12
I 2
S 1
D ADD 0000 2 e c d 0300 0
I 6
S 0
W
T stomp
K 2
D LI 00aa 0 8 0 0 00aa 0
D ADD 0000 1 5 2 3 0000 0
D ADD 0000 2 6 5 4 07d7 0
W
K 0

// File: test/tb_exec_cluster.sv
/*
 * Testbench for the issue stage: clock and reset, stimulus file reader,
 * result model with per-destination checks, and a watchdog
 */

`timescale 1ns/1ps

module tb_exec_cluster;
	import rs_pkg::*;

	localparam int NRSE = 4;
	localparam int NREG = 16;

	logic clk = 1'b0;
	logic rst;
	logic dispatch;
	opcode_e op;
	logic [15:0] imm;
	logic [1:0] rob;
	logic [3:0] dst;
	logic [3:0] src_a;
	logic [3:0] src_b;
	logic stall;
	logic [3:0] stomp;
	logic busy;
	logic res_valid;
	logic [3:0] res_dst;
	logic [15:0] res_data;

	int cyc = 0;
	string lines[$];
	int ncmd;
	string cur_test;
	int test_base;
	int pass_cnt;
	int fail_cnt;
	int err_cnt;
	int mon_err;
	int ndisp;
	int ndone;
	int stall_mark;
	// Per destination record of the operation that will write it
	logic [15:0] mreg [NREG];
	int p_seq [NREG];
	int done_seq [NREG];
	string p_op [NREG];
	logic [3:0] p_sa [NREG];
	logic [3:0] p_sb [NREG];
	logic [15:0] p_imm [NREG];
	logic [1:0] p_rob [NREG];
	logic [15:0] p_exp [NREG];
	int p_lat [NREG];
	int p_cyc [NREG];

	exec_cluster_top #(.NRSE(NRSE)) u_exec_cluster_top (
		.clk(clk),
		.rst(rst),
		.dispatch_i(dispatch),
		.op_i(op),
		.imm_i(imm),
		.rob_i(rob),
		.dst_i(dst),
		.src_a_i(src_a),
		.src_b_i(src_b),
		.stall_i(stall),
		.stomp_i(stomp),
		.busy_o(busy),
		.result_valid_o(res_valid),
		.result_dst_o(res_dst),
		.result_data_o(res_data)
	);

	always #4 clk = ~clk;

	always @(posedge clk)
		cyc <= cyc + 1;

	// ============================================================
	// Reference ALU and opcode names
	// ============================================================

	function automatic opcode_e op_code(string name);
		if (name == "LI")
			return OP_LI;
		if (name == "ADD")
			return OP_ADD;
		if (name == "SUB")
			return OP_SUB;
		if (name == "AND")
			return OP_AND;
		if (name == "XOR")
			return OP_XOR;
		return OP_NOP;
	endfunction

	// NOP and unknown names yield zero
	function automatic logic [15:0] alu_ref(string name, logic [15:0] a, logic [15:0] b,
		logic [15:0] k);
		logic [15:0] r;
		r = '0;
		if (name == "LI")
			r = k;
		else if (name == "ADD")
			r = a + b;
		else if (name == "SUB")
			r = a - b;
		else if (name == "AND")
			r = a & b;
		else if (name == "XOR")
			r = a ^ b;
		return r;
	endfunction

	// ============================================================
	// Result monitor that samples the bypass bus mid-cycle
	// ============================================================

	task automatic check_result();
		logic [3:0] d;
		logic [15:0] want;
		d = res_dst;
		if (done_seq[d] == p_seq[d]) begin
			$display("ERROR %s: result for r%0d arrived with no operation pending",
				cur_test, d);
			mon_err++;
		end else begin
			// A stomped operation retires as a NOP and writes zero
			if (stomp[p_rob[d]])
				want = '0;
			else
				want = alu_ref(p_op[d], mreg[p_sa[d]], mreg[p_sb[d]], p_imm[d]);
			if (want != p_exp[d]) begin
				$display("ERROR %s: r%0d model gives %h but the stimulus row expects %h",
					cur_test, d, want, p_exp[d]);
				mon_err++;
			end
			if (res_data !== p_exp[d]) begin
				$display("ERROR %s: r%0d expected %h actual %h", cur_test, d, p_exp[d], res_data);
				mon_err++;
			end
			if (p_lat[d] != 0 && cyc - p_cyc[d] != p_lat[d]) begin
				$display("ERROR %s: r%0d latency expected %0d actual %0d",
					cur_test, d, p_lat[d], cyc - p_cyc[d]);
				mon_err++;
			end
			// The model register array only moves in result order
			mreg[d] = want;
			done_seq[d] = p_seq[d];
			ndone++;
		end
	endtask

	initial begin
		forever begin
			@(negedge clk);
			if (!rst && res_valid === 1'b1)
				check_result();
		end
	end

	// ============================================================
	// Command tasks
	// ============================================================

	task automatic close_test();
		if (err_cnt + mon_err == test_base) begin
			$display("PASS %s", cur_test);
			pass_cnt++;
		end else begin
			$display("FAIL %s with %0d errors", cur_test, err_cnt + mon_err - test_base);
			fail_cnt++;
		end
	endtask

	task automatic start_test(string ln);
		string kind;
		string name;
		void'($sscanf(ln, "%s %s", kind, name));
		if (cur_test != "")
			close_test();
		cur_test = name;
		test_base = err_cnt + mon_err;
	endtask

	task automatic do_dispatch(string ln);
		string kind;
		string opn;
		logic [15:0] k;
		logic [1:0] r;
		logic [3:0] d;
		logic [3:0] a;
		logic [3:0] b;
		logic [15:0] e;
		int l;
		int nf;
		nf = $sscanf(ln, "%s %s %h %h %h %h %h %h %d", kind, opn, k, r, d, a, b, e, l);
		if (nf != 9) begin
			$display("ERROR %s: malformed dispatch line: %s", cur_test, ln);
			err_cnt++;
		end else begin
			// Dispatch is only strobed while the station has a free entry
			while (busy) begin
				@(posedge clk);
				#1;
			end
			if (done_seq[d] != p_seq[d]) begin
				$display("ERROR %s: r%0d dispatched again while still pending", cur_test, d);
				err_cnt++;
			end
			p_seq[d]++;
			p_op[d] = opn;
			p_sa[d] = a;
			p_sb[d] = b;
			p_imm[d] = k;
			p_rob[d] = r;
			p_exp[d] = e;
			p_lat[d] = l;
			// Accepted on the coming edge
			p_cyc[d] = cyc + 1;
			ndisp++;
			dispatch = 1'b1;
			op = op_code(opn);
			imm = k;
			rob = r;
			dst = d;
			src_a = a;
			src_b = b;
			@(posedge clk);
			#1;
			dispatch = 1'b0;
		end
	endtask

	task automatic set_stall(int v);
		if (v != 0) begin
			stall = 1'b1;
			stall_mark = ndone;
		end else begin
			stall = 1'b0;
			// Only the operation already issued may finish inside the window
			if (ndone - stall_mark > 1) begin
				$display("ERROR %s: results during stall expected at most 1 actual %0d",
					cur_test, ndone - stall_mark);
				err_cnt++;
			end
		end
	endtask

	task automatic check_busy(int v);
		if (busy !== 1'(v)) begin
			$display("ERROR %s: busy_o expected %0d actual %b", cur_test, v, busy);
			err_cnt++;
		end
	endtask

	task automatic idle(int n);
		repeat (n) @(posedge clk);
		#1;
	endtask

	task automatic wait_results();
		while (ndisp != ndone) begin
			@(posedge clk);
			#1;
		end
		if (busy) begin
			$display("ERROR %s: busy_o still high after every result arrived", cur_test);
			err_cnt++;
		end
	endtask

	// ============================================================
	// Main sequence
	// ============================================================

	initial begin
		int fd;
		string line;
		rst = 1'b1;
		dispatch = 1'b0;
		op = OP_NOP;
		imm = '0;
		rob = '0;
		dst = '0;
		src_a = '0;
		src_b = '0;
		stall = 1'b0;
		stomp = '0;
		cur_test = "";
		pass_cnt = 0;
		fail_cnt = 0;
		err_cnt = 0;
		mon_err = 0;
		ndisp = 0;
		ndone = 0;
		stall_mark = 0;
		for (int r = 0; r < NREG; r++) begin
			mreg[r] = '0;
			p_seq[r] = 0;
			done_seq[r] = 0;
		end
		fd = $fopen("test/rs_stimulus.txt", "r");
		if (fd == 0) begin
			$display("could not open the stimulus file test/rs_stimulus.txt");
			err_cnt++;
		end else begin
			// Comment lines start with a hash and blank lines are skipped
			while ($fgets(line, fd) != 0) begin
				if (line.len() > 0 && line.getc(0) != "#" && line.getc(0) != "\n")
					lines.push_back(line);
			end
			$fclose(fd);
		end
		ncmd = lines.size();
		if (ncmd == 0) begin
			$display("the stimulus file holds no commands");
			err_cnt++;
		end
		repeat (16) @(posedge clk);
		#1;
		rst = 1'b0;
		for (int i = 0; i < ncmd; i++) begin
			string kind;
			int val;
			kind = "";
			val = 0;
			void'($sscanf(lines[i], "%s %h", kind, val));
			if (kind == "T")
				start_test(lines[i]);
			else if (kind == "D")
				do_dispatch(lines[i]);
			else if (kind == "S")
				set_stall(val);
			else if (kind == "K")
				stomp = 4'(val);
			else if (kind == "B")
				check_busy(val);
			else if (kind == "I")
				idle(val);
			else if (kind == "W")
				wait_results();
			else begin
				$display("unknown command in stimulus line: %s", lines[i]);
				err_cnt++;
			end
		end
		if (cur_test != "")
			close_test();
		if (ndisp != ndone) begin
			$display("%0d results still outstanding at the end of the stimulus", ndisp - ndone);
			err_cnt++;
		end
		$display("tests passed %0d, failed %0d, errors %0d",
			pass_cnt, fail_cnt, err_cnt + mon_err);
		if (err_cnt + mon_err == 0 && fail_cnt == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

	// Watchdog budget is fifty cycles for every command line on top of the reset period
	initial begin
		wait (ncmd > 0);
		repeat (16 + 50 * ncmd) @(posedge clk);
		$display("watchdog expired at cycle %0d, the run did not finish in time", cyc);
		$display("TEST FAILED");
		$finish;
	end

endmodule
